// ==== rtl/pcUplink_macros.svh ====
`ifndef PCUPLINK_MACROS_SVH
`define PCUPLINK_MACROS_SVH

//////////////////////////////////////////////////
// word and field widths

// one word toward the PC
`define pcWordWidth 40
// payload of one word from the chip
`define bdDataWidth 34
// wall-clock time in time units
`define timeWidth 48
`define filtIdxWidth 10
`define filtStateWidth 27
`define hbEveryWidth 16

// time base, clock cycles per time unit
`define clksPerTimeUnit 4

//////////////////////////////////////////////////
// PC word layout

// fpga flag plus the five zero bits in front of BD data
`define bdPadWidth 6
// top two bits of every fpga-generated word
`define sfCode 2'b10
`define hbCode 2'b11
// filter index field, zero-extended
`define sfIdxFieldWidth 11
// heartbeat half index and time bits per half
`define hbHalfIdxWidth 14
`define hbTimeBits 24
`define hbLoHalf 14'd0
`define hbHiHalf 14'd1

`endif

// ==== rtl/pcUplinkPkg.sv ====
`include "pcUplink_macros.svh"

package pcUplinkPkg;

  //////////////////////////////////////////////////
  // plain vectors

  // one PC word, flag bit on top
  typedef logic [`pcWordWidth-1:0] pcWord;
  // chip payload, passed through untouched
  typedef logic [`bdDataWidth-1:0] bdData;
  // elapsed time in time units
  typedef logic [`timeWidth-1:0] timeStamp;
  // heartbeat period in time units, 0 turns heartbeats off
  typedef logic [`hbEveryWidth-1:0] hbPeriod;
  typedef logic [`filtIdxWidth-1:0] filtIdx;
  typedef logic [`filtStateWidth-1:0] filtState;

  //////////////////////////////////////////////////
  // channel beats, forward half only

  // the ack travels back as its own level
  typedef struct packed {
    logic valid;
    pcWord data;
  } pcBeat;

  typedef struct packed {
    logic valid;
    bdData data;
  } bdBeat;

  // one filtered spike event
  typedef struct packed {
    filtIdx idx;
    filtState state;
  } sfEvent;

  typedef struct packed {
    logic valid;
    sfEvent evt;
  } sfBeat;

  // heartbeat sender FSM
  typedef enum logic [1:0] {hbReady, hbSendLo, hbSendHi} hbState;

endpackage

// ==== rtl/channelMerge.sv ====
`timescale 1ns/10ps

module channelMerge (
  input logic clk,
  input logic reset,
  input pcUplinkPkg::pcBeat inA,
  output logic ackA,
  input pcUplinkPkg::pcBeat inB,
  output logic ackB,
  output pcUplinkPkg::pcBeat out,
  input logic outAck
);

  import pcUplinkPkg::*;

  // output register, valid and word kept apart
  logic outValid;
  pcWord outData;
  // set when A got the last slot, so B wins the next tie
  logic servedA;

  logic canTake;
  logic pickA;
  logic pickB;

  //////////////////////////////////////////////////
  // input selection

  // register is free, or its word leaves this cycle
  assign canTake = !outValid || outAck;

  // alternate on a tie, otherwise take whoever is valid
  assign pickA = inA.valid && (!inB.valid || !servedA);
  assign pickB = inB.valid && !pickA;

  // acks only when the word really lands in the register
  assign ackA = canTake && pickA;
  assign ackB = canTake && pickB;

  //////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (canTake) begin
      // empties when nothing new is offered
      outValid <= pickA || pickB;
    end
  end

  // payload moves only on a take, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (canTake && (pickA || pickB)) begin
      outData <= pickA ? inA.data : inB.data;
    end
  end

  // priority flag follows the input just served
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // first input has priority after reset
      servedA <= 1'b0;
    end else if (canTake && (pickA || pickB)) begin
      servedA <= pickA;
    end
  end

  assign out.valid = outValid;
  assign out.data = outData;

endmodule

// ==== rtl/heartbeatSender.sv ====
`timescale 1ns/10ps
`include "pcUplink_macros.svh"

module heartbeatSender (
  input logic clk,
  input logic reset,
  input logic hbStrobe,
  input pcUplinkPkg::timeStamp elapsed,
  output pcUplinkPkg::pcBeat hbOut,
  input logic hbAck
);

  import pcUplinkPkg::*;

  hbState state;
  hbState nextState;
  // time captured on the strobe, both halves come from here
  timeStamp timeLatch;

  //////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= hbReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      // a strobe while busy is simply missed
      hbReady: if (hbStrobe) nextState = hbSendLo;
      hbSendLo: if (hbAck) nextState = hbSendHi;
      hbSendHi: if (hbAck) nextState = hbReady;
      default: nextState = hbReady;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == hbReady && hbStrobe) begin
      timeLatch <= elapsed;
    end
  end

  //////////////////////////////////////////////////
  // output word

  always_comb begin
    hbOut.valid = (state != hbReady);
    // low half first, index 0
    hbOut.data = {`hbCode, `hbLoHalf, timeLatch[`hbTimeBits-1:0]};
    if (state == hbSendHi) begin
      hbOut.data = {`hbCode, `hbHiHalf, timeLatch[`timeWidth-1:`hbTimeBits]};
    end
  end

endmodule

// ==== rtl/timeMgr.sv ====
`timescale 1ns/10ps
`include "pcUplink_macros.svh"

module timeMgr (
  input logic clk,
  input logic reset,
  input pcUplinkPkg::hbPeriod hbEvery,
  output pcUplinkPkg::timeStamp elapsed,
  output logic hbStrobe
);

  import pcUplinkPkg::*;

  typedef logic [$clog2(`clksPerTimeUnit)-1:0] preCount;

  // cycle count within the current time unit
  preCount prescale;
  logic unitTick;
  // units since the last heartbeat
  hbPeriod sinceHb;
  hbPeriod sinceHbNext;
  logic hbDue;

  //////////////////////////////////////////////////
  // time base

  // last cycle of a time unit
  assign unitTick = (prescale == preCount'(`clksPerTimeUnit - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescale <= '0;
      elapsed <= '0;
    end else if (unitTick) begin
      prescale <= '0;
      elapsed <= elapsed + 1'b1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // heartbeat strobe

  assign sinceHbNext = sinceHb + 1'b1;
  // >= also catches a period shortened mid-count
  assign hbDue = (hbEvery != '0) && (sinceHbNext >= hbEvery);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sinceHb <= '0;
    end else if (hbEvery == '0) begin
      // heartbeats off, count starts over
      sinceHb <= '0;
    end else if (unitTick) begin
      sinceHb <= hbDue ? '0 : sinceHbNext;
    end
  end

  // one cycle, aligned with the new elapsed value
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hbStrobe <= 1'b0;
    end else begin
      hbStrobe <= unitTick && hbDue;
    end
  end

endmodule

// ==== rtl/pcPacker.sv ====
`timescale 1ns/10ps
`include "pcUplink_macros.svh"

module pcPacker (
  input logic clk,
  input logic reset,
  input pcUplinkPkg::bdBeat bdIn,
  output logic bdAck,
  input pcUplinkPkg::sfBeat sfIn,
  output logic sfAck,
  input logic hbStrobe,
  input pcUplinkPkg::timeStamp elapsed,
  output pcUplinkPkg::pcBeat pcOut,
  input logic pcAck
);

  import pcUplinkPkg::*;

  // every source reformatted to the PC word
  pcBeat bdPacked;
  logic bdPackedAck;
  pcBeat sfPacked;
  logic sfPackedAck;
  pcBeat hbPacked;
  logic hbPackedAck;

  // leaf merge output into the root
  pcBeat leafOut;
  logic leafOutAck;

  //////////////////////////////////////////////////
  // chip words

  // flag 0 and five zero bits ahead of the payload
  assign bdPacked.valid = bdIn.valid;
  assign bdPacked.data = {`bdPadWidth'(0), bdIn.data};
  assign bdAck = bdPackedAck;

  //////////////////////////////////////////////////
  // filtered spikes

  // flags 1,0 then index padded to 11 bits, then the state
  assign sfPacked.valid = sfIn.valid;
  assign sfPacked.data = {`sfCode, `sfIdxFieldWidth'(sfIn.evt.idx), sfIn.evt.state};
  assign sfAck = sfPackedAck;

  //////////////////////////////////////////////////
  // heartbeat, two words per strobe

  heartbeatSender hbSender (
    .clk(clk),
    .reset(reset),
    .hbStrobe(hbStrobe),
    .elapsed(elapsed),
    .hbOut(hbPacked),
    .hbAck(hbPackedAck)
  );

  //////////////////////////////////////////////////
  // merge tree

  // spikes and heartbeats share one leaf
  channelMerge leafMerge (
    .clk(clk),
    .reset(reset),
    .inA(sfPacked),
    .ackA(sfPackedAck),
    .inB(hbPacked),
    .ackB(hbPackedAck),
    .out(leafOut),
    .outAck(leafOutAck)
  );

  // chip words get the short path, one cycle
  channelMerge rootMerge (
    .clk(clk),
    .reset(reset),
    .inA(bdPacked),
    .ackA(bdPackedAck),
    .inB(leafOut),
    .ackB(leafOutAck),
    .out(pcOut),
    .outAck(pcAck)
  );

endmodule

// ==== rtl/pcUplink.sv ====
`timescale 1ns/10ps

module pcUplink (
  input logic clk,
  input logic reset,
  input pcUplinkPkg::hbPeriod hbEvery,
  input pcUplinkPkg::bdBeat bdIn,
  output logic bdAck,
  input pcUplinkPkg::sfBeat sfIn,
  output logic sfAck,
  output pcUplinkPkg::pcBeat pcOut,
  input logic pcAck
);

  import pcUplinkPkg::*;

  // wall time and heartbeat pulse into the packer
  timeStamp elapsed;
  logic hbStrobe;

  timeMgr timeMgr_i (
    .clk(clk),
    .reset(reset),
    .hbEvery(hbEvery),
    .elapsed(elapsed),
    .hbStrobe(hbStrobe)
  );

  pcPacker pcPacker_i (
    .clk(clk),
    .reset(reset),
    .bdIn(bdIn),
    .bdAck(bdAck),
    .sfIn(sfIn),
    .sfAck(sfAck),
    .hbStrobe(hbStrobe),
    .elapsed(elapsed),
    .pcOut(pcOut),
    .pcAck(pcAck)
  );

endmodule

// ==== test/pcUplinkChecker.sv ====
`timescale 1ns/10ps
`include "pcUplink_macros.svh"

module pcUplinkChecker (
  input logic clk,
  input logic reset,
  input pcUplinkPkg::hbPeriod hbEvery,
  input pcUplinkPkg::bdBeat bdIn,
  input logic bdAck,
  input pcUplinkPkg::sfBeat sfIn,
  input logic sfAck,
  input pcUplinkPkg::pcBeat pcOut,
  input logic pcAck,
  output int pending,
  output int errorCount,
  output int testsPassed,
  output int testsFailed
);

  import pcUplinkPkg::*;

  string testName;
  int testErrors;
  // expected words per source, in acceptance order
  pcWord expBd [$];
  pcWord expSf [$];
  // set per BD word when a spike event was already waiting
  bit bdFairFlags [$];
  bit lastFlaggedBd;
  bit sfValidPrev;
  // heartbeat pairing
  bit hbWaitHi;
  logic [`hbTimeBits-1:0] hbLoBits;
  timeStamp lastHbTime;
  int hbPairs;
  // stalled word seen on the previous edge
  bit holdCheck;
  pcWord heldWord;
  bit resetSeen;

  initial begin
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    pending = 0;
    testName = "none";
  end

  task automatic reportFailure(input string what);
    $display("test %s %s", testName, what);
    testErrors++;
    errorCount++;
  endtask

  task automatic reportMismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("mismatch test %s %s expected %h actual %h", testName, what, exp, act);
    testErrors++;
    errorCount++;
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrors = 0;
    expBd.delete();
    expSf.delete();
    bdFairFlags.delete();
    lastFlaggedBd = 1'b0;
    hbWaitHi = 1'b0;
    lastHbTime = '0;
    hbPairs = 0;
    pending = 0;
  endtask

  task automatic endTest();
    if (expBd.size() != 0) reportFailure($sformatf("lost %0d BD words", expBd.size()));
    if (expSf.size() != 0) reportFailure($sformatf("lost %0d spike words", expSf.size()));
    if (hbEvery != '0 && hbPairs == 0) reportFailure("saw no heartbeat at all");
    if (testErrors == 0) begin
      testsPassed++;
      $display("test %s passed with %0d heartbeats", testName, hbPairs);
    end else begin
      testsFailed++;
      $display("test %s failed with %0d errors", testName, testErrors);
    end
  endtask

  //////////////////////////////////////////////////
  // heartbeat words, low half then high half

  task automatic checkHeartbeat(input pcWord word);
    timeStamp hbTime;
    if (hbEvery == '0) begin
      reportFailure("got a heartbeat while heartbeats are off");
    end else if (!hbWaitHi) begin
      if (word[37:24] != 14'd0) reportMismatch("heartbeat low index", 0, word[37:24]);
      hbLoBits = word[23:0];
      hbWaitHi = 1'b1;
    end else begin
      if (word[37:24] != 14'd1) reportMismatch("heartbeat high index", 1, word[37:24]);
      hbTime = {word[23:0], hbLoBits};
      hbWaitHi = 1'b0;
      hbPairs++;
      if (hbTime == '0 || hbTime % hbEvery != 0) begin
        reportFailure($sformatf("heartbeat time %0d is no multiple of %0d", hbTime, hbEvery));
      end
      if (hbTime <= lastHbTime) reportFailure("heartbeat time did not move forward");
      lastHbTime = hbTime;
    end
  endtask

  // classify by the two top bits and compare with the matching queue
  task automatic checkOutput(input pcWord word);
    pcWord expected;
    bit flagged;
    if (word[39] == 1'b0) begin
      if (expBd.size() == 0) begin
        reportFailure($sformatf("got unexpected BD word %h", word));
      end else begin
        expected = expBd.pop_front();
        flagged = bdFairFlags.pop_front();
        if (word != expected) reportMismatch("BD word", expected, word);
        if (lastFlaggedBd) reportFailure("sent two BD words in a row while spikes waited");
        lastFlaggedBd = flagged;
      end
    end else begin
      lastFlaggedBd = 1'b0;
      if (word[38] == 1'b1) begin
        checkHeartbeat(word);
      end else if (expSf.size() == 0) begin
        reportFailure($sformatf("got unexpected spike word %h", word));
      end else begin
        expected = expSf.pop_front();
        if (word != expected) reportMismatch("spike word", expected, word);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // port monitor

  always @(posedge clk) begin
    if (reset) begin
      if (pcOut.valid || bdAck || sfAck) reportFailure("has valid or ack high in reset");
      resetSeen = 1'b1;
      holdCheck = 1'b0;
      sfValidPrev = 1'b0;
    end else begin
      if (resetSeen && (pcOut.valid || bdAck || sfAck)) begin
        reportFailure("has valid or ack high right after reset");
      end
      resetSeen = 1'b0;
      if (holdCheck && (!pcOut.valid || pcOut.data != heldWord)) begin
        reportMismatch("stalled pcOut word", heldWord, pcOut.data);
      end
      holdCheck = pcOut.valid && !pcAck;
      heldWord = pcOut.data;
      if (pcOut.valid && pcAck) checkOutput(pcOut.data);
      // expected words straight from the PC word format
      if (bdIn.valid && bdAck) begin
        expBd.push_back({6'b0, bdIn.data});
        bdFairFlags.push_back(sfValidPrev);
      end
      if (sfIn.valid && sfAck) expSf.push_back({2'b10, 1'b0, sfIn.evt.idx, sfIn.evt.state});
      sfValidPrev = sfIn.valid;
      pending = expBd.size() + expSf.size();
    end
  end

endmodule

// ==== test/pcUplinkTb.sv ====
`timescale 1ns/10ps
`include "pcUplink_macros.svh"

module pcUplinkTb;

  import pcUplinkPkg::*;

  localparam int nTests = 6;
  localparam int resetCycles = 5;

  logic clk;
  logic reset;
  hbPeriod hbEvery;
  bdBeat bdIn;
  logic bdAck;
  sfBeat sfIn;
  logic sfAck;
  pcBeat pcOut;
  logic pcAck;

  //////////////////////////////////////////////////
  // test table, one column per array

  string testNames [nTests] = '{"bdOnly", "sfOnly", "mixedHb", "fairness", "heavyStall", "fastHb"};
  int bdCounts [nTests] = '{40, 0, 50, 60, 60, 30};
  int sfCounts [nTests] = '{0, 40, 50, 60, 60, 30};
  int hbPeriods [nTests] = '{0, 0, 6, 0, 5, 1};
  int gapLimits [nTests] = '{3, 3, 4, 0, 2, 1};
  int stallPcts [nTests] = '{0, 0, 20, 0, 75, 50};

  int stallPct;
  int cycleCount;
  int cycleLimit;
  int pending;
  int errorCount;
  int testsPassed;
  int testsFailed;

  pcUplink pcUplink_i (
    .clk(clk), .reset(reset), .hbEvery(hbEvery),
    .bdIn(bdIn), .bdAck(bdAck), .sfIn(sfIn), .sfAck(sfAck),
    .pcOut(pcOut), .pcAck(pcAck)
  );

  pcUplinkChecker checker_i (
    .clk(clk), .reset(reset), .hbEvery(hbEvery),
    .bdIn(bdIn), .bdAck(bdAck), .sfIn(sfIn), .sfAck(sfAck),
    .pcOut(pcOut), .pcAck(pcAck), .pending(pending), .errorCount(errorCount),
    .testsPassed(testsPassed), .testsFailed(testsFailed)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // sink stalls at the row's rate
  always @(negedge clk) begin
    pcAck = ($urandom_range(99, 0) >= stallPct);
  end

  // ack is sampled mid-cycle, where it is settled
  task automatic sendBd(input int count, input int gapLimit);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = $urandom_range(gapLimit, 0);
      bdIn.valid = 1'b0;
      repeat (gap) @(negedge clk);
      bdIn.valid = 1'b1;
      bdIn.data = bdData'({$urandom, $urandom});
      #1;
      while (!bdAck) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    bdIn.valid = 1'b0;
  endtask

  // random index over all its bits, random state
  task automatic sendSf(input int count, input int gapLimit);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = $urandom_range(gapLimit, 0);
      sfIn.valid = 1'b0;
      repeat (gap) @(negedge clk);
      sfIn.valid = 1'b1;
      sfIn.evt = sfEvent'({$urandom, $urandom});
      #1;
      while (!sfAck) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    sfIn.valid = 1'b0;
  endtask

  // each row starts from reset so elapsed restarts at zero
  task automatic runTest(input int row);
    @(negedge clk);
    reset = 1'b1;
    hbEvery = hbPeriod'(hbPeriods[row]);
    stallPct = stallPcts[row];
    checker_i.startTest(testNames[row]);
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
    // inputs stay idle on the first cycle out of reset
    @(negedge clk);
    fork
      sendBd(bdCounts[row], gapLimits[row]);
      sendSf(sfCounts[row], gapLimits[row]);
    join
    while (pending != 0) @(negedge clk);
    repeat (2 * hbPeriods[row] * `clksPerTimeUnit) @(negedge clk);
    checker_i.endTest();
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    void'($urandom(32'h1e17));
    reset = 1'b1;
    hbEvery = '0;
    bdIn = '0;
    sfIn = '0;
    pcAck = 1'b0;
    stallPct = 0;
    // per row, words x4 stretched by gaps and stalls, plus idle and reset
    cycleLimit = 1000;
    for (int r = 0; r < nTests; r++) begin
      cycleLimit += (bdCounts[r] + sfCounts[r]) * 4 * (gapLimits[r] + 1) * 100
        / (100 - stallPcts[r]) + 2 * hbPeriods[r] * `clksPerTimeUnit + resetCycles + 2;
    end
    for (int r = 0; r < nTests; r++) begin
      runTest(r);
    end
    $display("tests %0d passed %0d failed %0d errors %0d",
      nTests, testsPassed, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, limit is set at time 0
  initial begin
    cycleCount = 0;
    @(posedge clk);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the tests did not complete", cycleCount);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/pcUplinkPkg.sv
rtl/channelMerge.sv
rtl/heartbeatSender.sv
rtl/timeMgr.sv
rtl/pcPacker.sv
rtl/pcUplink.sv
test/pcUplinkChecker.sv
test/pcUplinkTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pcUplink testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module pcUplinkTb \
  -Mdir obj_dir -o pcUplinkSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# simulation output goes to a log for the verdict below
./obj_dir/pcUplinkSim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
exit 1
